// File: acc_cpu_macros.svh
`ifndef ACC_CPU_MACROS_SVH
`define ACC_CPU_MACROS_SVH

// datapath and instruction word
`define ACC_CPU_DATA_W 16
// instruction class and alu op fields
`define ACC_CPU_OP_W 4

// word memory geometry
`define ACC_CPU_ADDR_W 8
`define ACC_CPU_MEM_DEPTH 256

// apb bus widths
`define ACC_CPU_PADDR_W 12
`define ACC_CPU_PDATA_W 32

// register map, byte offsets
`define ACC_CPU_REG_CTRL 12'h000
`define ACC_CPU_REG_STATUS 12'h004
`define ACC_CPU_REG_ACC 12'h008
`define ACC_CPU_REG_PC 12'h00C
// memory window, word i sits at base + 4*i
`define ACC_CPU_MEM_BASE 12'h400

`endif

// File: acc_cpu_pkg.sv
`default_nettype none

`include "acc_cpu_macros.svh"

package acc_cpu_pkg;

    // instruction classes, unlisted codes behave as halt
    typedef enum logic [`ACC_CPU_OP_W-1:0] {
        LOAD  = 4'd0,
        STORE = 4'd1,
        ALU   = 4'd2,
        JUMP  = 4'd3,
        JUMPZ = 4'd4,
        HALT  = 4'd5
    } instr_class_e;

    // alu operations in reference order
    typedef enum logic [`ACC_CPU_OP_W-1:0] {
        ADD, SUB, MUL, DIV, SHL, SHR, ROL, ROR,
        AND, OR, XOR, NOR, NAND, XNOR, GT, EQ
    } alu_op_e;

    typedef enum logic [2:0] {
        IDLE, FETCH, DECODE, EXECUTE, HALTED
    } core_state_e;

    // class | op | address
    typedef struct packed {
        instr_class_e               cls;
        alu_op_e                    op;
        logic [`ACC_CPU_ADDR_W-1:0] addr;
    } instr_t;

    typedef struct packed {
        logic                       en;
        logic                       we;
        logic [`ACC_CPU_ADDR_W-1:0] addr;
        logic [`ACC_CPU_DATA_W-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                       start;
        logic [`ACC_CPU_ADDR_W-1:0] start_pc;
    } core_cmd_t;

    typedef struct packed {
        logic                       busy;
        logic                       halted;
        logic [`ACC_CPU_DATA_W-1:0] acc;
        logic [`ACC_CPU_ADDR_W-1:0] pc;
    } core_status_t;

endpackage

`default_nettype wire

// File: acc_cpu_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "acc_cpu_macros.svh"

module acc_cpu_alu (
    input  wire acc_cpu_pkg::alu_op_e     op,
    input  wire [`ACC_CPU_DATA_W-1:0]     a,
    input  wire [`ACC_CPU_DATA_W-1:0]     b,
    output logic [`ACC_CPU_DATA_W-1:0]    result
);

    // full product of which only the low half is kept
    logic [2*`ACC_CPU_DATA_W-1:0] product;

    assign product = {{`ACC_CPU_DATA_W{1'b0}}, a} * {{`ACC_CPU_DATA_W{1'b0}}, b};

    always_comb begin
        case (op)
            acc_cpu_pkg::ADD:  result = a + b;
            acc_cpu_pkg::SUB:  result = a - b;
            acc_cpu_pkg::MUL:  result = product[`ACC_CPU_DATA_W-1:0];
            // divide by zero saturates to all ones
            acc_cpu_pkg::DIV:  result = (b == '0) ? '1 : a / b;
            // shifts and rotates move a by one bit and ignore b
            acc_cpu_pkg::SHL:  result = a << 1;
            acc_cpu_pkg::SHR:  result = a >> 1;
            acc_cpu_pkg::ROL:  result = {a[`ACC_CPU_DATA_W-2:0], a[`ACC_CPU_DATA_W-1]};
            acc_cpu_pkg::ROR:  result = {a[0], a[`ACC_CPU_DATA_W-1:1]};
            acc_cpu_pkg::AND:  result = a & b;
            acc_cpu_pkg::OR:   result = a | b;
            acc_cpu_pkg::XOR:  result = a ^ b;
            acc_cpu_pkg::NOR:  result = ~(a | b);
            acc_cpu_pkg::NAND: result = ~(a & b);
            acc_cpu_pkg::XNOR: result = ~(a ^ b);
            // unsigned compares give 1 or 0
            acc_cpu_pkg::GT:   result = (a > b) ? `ACC_CPU_DATA_W'(1) : '0;
            acc_cpu_pkg::EQ:   result = (a == b) ? `ACC_CPU_DATA_W'(1) : '0;
            default:           result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: acc_cpu_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "acc_cpu_macros.svh"

module acc_cpu_mem (
    input  wire                           clock,
    input  wire acc_cpu_pkg::mem_req_t    core_req,
    input  wire acc_cpu_pkg::mem_req_t    host_req,
    output logic [`ACC_CPU_DATA_W-1:0]    rdata
);

    logic [`ACC_CPU_DATA_W-1:0] mem [`ACC_CPU_MEM_DEPTH];

    // winning request
    acc_cpu_pkg::mem_req_t sel;

    // core has priority, host only talks to an idle core anyway
    assign sel = core_req.en ? core_req : host_req;

    always_ff @(posedge clock) begin
        if (sel.en) begin
            if (sel.we) begin
                mem[sel.addr] <= sel.wdata;
            end else begin
                // registered read, data shows up next cycle
                rdata <= mem[sel.addr];
            end
        end
    end

endmodule

`default_nettype wire

// File: acc_cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "acc_cpu_macros.svh"

module acc_cpu_core (
    input  wire                               clock,
    input  wire                               arst_n,
    input  wire acc_cpu_pkg::core_cmd_t       cmd,
    input  wire [`ACC_CPU_DATA_W-1:0]         mem_rdata,
    input  wire [`ACC_CPU_DATA_W-1:0]         alu_result,
    output acc_cpu_pkg::mem_req_t             mem_req,
    output acc_cpu_pkg::alu_op_e              alu_op,
    output logic [`ACC_CPU_DATA_W-1:0]        alu_a,
    output logic [`ACC_CPU_DATA_W-1:0]        alu_b,
    output acc_cpu_pkg::core_status_t         status
);

    acc_cpu_pkg::core_state_e     state;
    acc_cpu_pkg::instr_t          ir;
    // word coming back from the fetch read, valid in DECODE
    acc_cpu_pkg::instr_t          fetched;
    logic [`ACC_CPU_DATA_W-1:0]   acc;
    logic [`ACC_CPU_ADDR_W-1:0]   pc;
    logic                         needs_operand;

    assign fetched = acc_cpu_pkg::instr_t'(mem_rdata);

    // load and alu read their operand during DECODE
    assign needs_operand = (fetched.cls == acc_cpu_pkg::LOAD) ||
                           (fetched.cls == acc_cpu_pkg::ALU);

    // operand arrives on mem_rdata in EXECUTE
    assign alu_op = ir.op;
    assign alu_a  = acc;
    assign alu_b  = mem_rdata;

    assign status.busy   = (state == acc_cpu_pkg::FETCH) ||
                           (state == acc_cpu_pkg::DECODE) ||
                           (state == acc_cpu_pkg::EXECUTE);
    assign status.halted = (state == acc_cpu_pkg::HALTED);
    assign status.acc    = acc;
    assign status.pc     = pc;

    // instruction register, only loaded in DECODE
    always_ff @(posedge clock) begin
        if (state == acc_cpu_pkg::DECODE) begin
            ir <= fetched;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= acc_cpu_pkg::IDLE;
            acc   <= '0;
            pc    <= '0;
        end else begin
            case (state)
                // a start from idle or halted restarts at start_pc
                acc_cpu_pkg::IDLE,
                acc_cpu_pkg::HALTED: begin
                    if (cmd.start) begin
                        pc    <= cmd.start_pc;
                        state <= acc_cpu_pkg::FETCH;
                    end
                end
                acc_cpu_pkg::FETCH: begin
                    state <= acc_cpu_pkg::DECODE;
                end
                acc_cpu_pkg::DECODE: begin
                    state <= acc_cpu_pkg::EXECUTE;
                end
                acc_cpu_pkg::EXECUTE: begin
                    // sequential flow unless overridden below, pc wraps at 255
                    pc    <= pc + 1'b1;
                    state <= acc_cpu_pkg::FETCH;
                    case (ir.cls)
                        acc_cpu_pkg::LOAD:  acc <= mem_rdata;
                        acc_cpu_pkg::ALU:   acc <= alu_result;
                        // write itself goes out on mem_req
                        acc_cpu_pkg::STORE: acc <= acc;
                        acc_cpu_pkg::JUMP:  pc <= ir.addr;
                        acc_cpu_pkg::JUMPZ: begin
                            if (acc == '0) begin
                                pc <= ir.addr;
                            end
                        end
                        // halt and unknown codes, pc stays on this instruction
                        default: begin
                            pc    <= pc;
                            state <= acc_cpu_pkg::HALTED;
                        end
                    endcase
                end
                default: state <= acc_cpu_pkg::IDLE;
            endcase
        end
    end

    // memory requests per state
    always_comb begin
        mem_req = '0;
        case (state)
            acc_cpu_pkg::FETCH: begin
                mem_req.en   = 1'b1;
                mem_req.addr = pc;
            end
            acc_cpu_pkg::DECODE: begin
                mem_req.en   = needs_operand;
                mem_req.addr = fetched.addr;
            end
            acc_cpu_pkg::EXECUTE: begin
                if (ir.cls == acc_cpu_pkg::STORE) begin
                    mem_req.en    = 1'b1;
                    mem_req.we    = 1'b1;
                    mem_req.addr  = ir.addr;
                    mem_req.wdata = acc;
                end
            end
            default: mem_req = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: acc_cpu_apb_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "acc_cpu_macros.svh"

module acc_cpu_apb_port (
    input  wire                               clock,
    input  wire                               arst_n,
    input  wire [`ACC_CPU_PADDR_W-1:0]        paddr,
    input  wire                               psel,
    input  wire                               penable,
    input  wire                               pwrite,
    input  wire [`ACC_CPU_PDATA_W-1:0]        pwdata,
    input  wire acc_cpu_pkg::core_status_t    status,
    input  wire [`ACC_CPU_DATA_W-1:0]         mem_rdata,
    output logic [`ACC_CPU_PDATA_W-1:0]       prdata,
    output logic                              pready,
    output logic                              pslverr,
    output acc_cpu_pkg::mem_req_t             mem_req,
    output acc_cpu_pkg::core_cmd_t            cmd
);

    logic                         access;
    logic                         hit_ctrl;
    logic                         hit_status;
    logic                         hit_acc;
    logic                         hit_pc;
    logic                         hit_mem;
    logic [`ACC_CPU_PADDR_W-1:0]  mem_off;
    logic                         err;
    logic                         mem_rd;
    // second access cycle of a memory read
    logic                         rd_wait;
    logic                         start_now;

    assign access = psel & penable;

    // address decode
    assign hit_ctrl   = (paddr == `ACC_CPU_REG_CTRL);
    assign hit_status = (paddr == `ACC_CPU_REG_STATUS);
    assign hit_acc    = (paddr == `ACC_CPU_REG_ACC);
    assign hit_pc     = (paddr == `ACC_CPU_REG_PC);
    assign mem_off    = paddr - `ACC_CPU_MEM_BASE;
    // word aligned addresses inside the window only
    assign hit_mem    = (paddr >= `ACC_CPU_MEM_BASE) &&
                        (paddr < `ACC_CPU_MEM_BASE +
                                 `ACC_CPU_PADDR_W'(4 * `ACC_CPU_MEM_DEPTH)) &&
                        (paddr[1:0] == 2'b00);

    // unmapped address or memory access or ctrl write while busy
    assign err = ~(hit_ctrl | hit_status | hit_acc | hit_pc | hit_mem) |
                 (hit_mem & status.busy) |
                 (hit_ctrl & pwrite & status.busy);

    assign mem_rd = access & hit_mem & ~pwrite & ~status.busy;

    // memory reads stall one cycle for the registered read
    assign pready  = ~(mem_rd & ~rd_wait);
    assign pslverr = access & pready & err;

    // one cycle request that is never issued while busy
    assign mem_req.en    = access & hit_mem & ~status.busy & ~rd_wait;
    assign mem_req.we    = pwrite;
    assign mem_req.addr  = mem_off[`ACC_CPU_ADDR_W+1:2];
    assign mem_req.wdata = pwdata[`ACC_CPU_DATA_W-1:0];

    assign start_now = access & hit_ctrl & pwrite & ~err & pwdata[0];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            rd_wait <= 1'b0;
            cmd     <= '0;
        end else begin
            rd_wait   <= mem_rd & ~rd_wait;
            // start pulse lasts one cycle
            cmd.start <= start_now;
            if (start_now) begin
                cmd.start_pc <= pwdata[15:8];
            end
        end
    end

    // ctrl and unmapped addresses read back as zero
    always_comb begin
        prdata = '0;
        if (hit_status) begin
            prdata[1:0] = {status.halted, status.busy};
        end else if (hit_acc) begin
            prdata[`ACC_CPU_DATA_W-1:0] = status.acc;
        end else if (hit_pc) begin
            prdata[`ACC_CPU_ADDR_W-1:0] = status.pc;
        end else if (hit_mem) begin
            prdata[`ACC_CPU_DATA_W-1:0] = mem_rdata;
        end
    end

endmodule

`default_nettype wire

// File: acc_cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "acc_cpu_macros.svh"

module acc_cpu_top (
    input  wire                               clock,
    input  wire                               arst_n,
    input  wire [`ACC_CPU_PADDR_W-1:0]        paddr,
    input  wire                               psel,
    input  wire                               penable,
    input  wire                               pwrite,
    input  wire [`ACC_CPU_PDATA_W-1:0]        pwdata,
    output logic [`ACC_CPU_PDATA_W-1:0]       prdata,
    output logic                              pready,
    output logic                              pslverr
);

    acc_cpu_pkg::mem_req_t        host_req;
    acc_cpu_pkg::mem_req_t        core_req;
    acc_cpu_pkg::core_cmd_t       cmd;
    acc_cpu_pkg::core_status_t    status;
    acc_cpu_pkg::alu_op_e         alu_op;
    logic [`ACC_CPU_DATA_W-1:0]   mem_rdata;
    logic [`ACC_CPU_DATA_W-1:0]   alu_a;
    logic [`ACC_CPU_DATA_W-1:0]   alu_b;
    logic [`ACC_CPU_DATA_W-1:0]   alu_result;

    // host side, registers and memory window
    acc_cpu_apb_port i_acc_cpu_apb_port (
        .clock     (clock),
        .arst_n    (arst_n),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .status    (status),
        .mem_rdata (mem_rdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .mem_req   (host_req),
        .cmd       (cmd)
    );

    acc_cpu_core i_acc_cpu_core (
        .clock      (clock),
        .arst_n     (arst_n),
        .cmd        (cmd),
        .mem_rdata  (mem_rdata),
        .alu_result (alu_result),
        .mem_req    (core_req),
        .alu_op     (alu_op),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .status     (status)
    );

    acc_cpu_alu i_acc_cpu_alu (
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result)
    );

    // shared by core and host, core first
    acc_cpu_mem i_acc_cpu_mem (
        .clock    (clock),
        .core_req (core_req),
        .host_req (host_req),
        .rdata    (mem_rdata)
    );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clock,
    output logic arst_n
);

    // 20 ns period
    localparam int HALF_PERIOD = 10;

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    // reset held for 8 cycles, released on a falling edge
    initial begin
        arst_n = 1'b0;
        repeat (8) @(negedge clock);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: tb_acc_cpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "acc_cpu_macros.svh"

module tb_acc_cpu;

    // transfer and halt polling limits
    localparam int HOST_TIMEOUT = 16;
    localparam int HALT_TIMEOUT = 1000;

    // instruction classes in encoding order
    localparam logic [3:0] CLS_LOAD  = 4'd0;
    localparam logic [3:0] CLS_STORE = 4'd1;
    localparam logic [3:0] CLS_ALU   = 4'd2;
    localparam logic [3:0] CLS_JUMP  = 4'd3;
    localparam logic [3:0] CLS_JUMPZ = 4'd4;
    localparam logic [3:0] CLS_HALT  = 4'd5;

    logic                         clock;
    logic                         arst_n;
    logic [`ACC_CPU_PADDR_W-1:0]  paddr;
    logic                         psel;
    logic                         penable;
    logic                         pwrite;
    logic [`ACC_CPU_PDATA_W-1:0]  pwdata;
    logic [`ACC_CPU_PDATA_W-1:0]  prdata;
    logic                         pready;
    logic                         pslverr;

    // software image of memory and core registers
    logic [15:0]                  model_mem [256];
    logic [15:0]                  model_acc;
    logic [7:0]                   model_pc;

    // results of the last apb transfer
    logic [31:0]                  rd_data;
    logic                         rd_err;
    int                           wait_cycles;

    integer                       seed;
    int                           waited;
    logic [7:0]                   addrs [8];
    logic [15:0]                  x;
    logic [15:0]                  y;
    logic [15:0]                  n;
    logic [3:0]                   op;

    tb_clock_gen i_tb_clock_gen (
        .clock  (clock),
        .arst_n (arst_n)
    );

    acc_cpu_top i_acc_cpu_top (
        .clock   (clock),
        .arst_n  (arst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    task automatic fail_now(input string what);
        $display("ERROR at %0t: %s", $time, what);
        $display("*** FAILED ***");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s got 0x%08h expected 0x%08h",
                     $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [15:0] instr(input logic [3:0] cls, input logic [3:0] code,
                                          input logic [7:0] addr);
        return {cls, code, addr};
    endfunction

    function automatic logic [11:0] mem_addr(input logic [7:0] idx);
        return `ACC_CPU_MEM_BASE + {2'b00, idx, 2'b00};
    endfunction

    // one apb transfer with setup and then access until pready
    task automatic apb_access(input logic write, input logic [11:0] addr,
                              input logic [31:0] data);
        int polls;
        polls = 0;
        @(negedge clock);
        paddr   = addr;
        pwrite  = write;
        pwdata  = data;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clock);
        penable = 1'b1;
        // sample mid phase away from both edges
        #5;
        while (!pready) begin
            polls++;
            if (polls > HOST_TIMEOUT) begin
                fail_now("APB transfer never completed, pready stayed low");
            end else begin
                @(negedge clock);
                #5;
            end
        end
        wait_cycles = polls;
        rd_data     = prdata;
        rd_err      = pslverr;
        @(negedge clock);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic host_write(input logic [11:0] addr, input logic [31:0] data,
                              input logic exp_err);
        apb_access(1'b1, addr, data);
        check_value("pslverr", 32'(rd_err), 32'(exp_err));
        check_value("pready wait", 32'(wait_cycles), 32'd0);
    endtask

    // memory reads without error take one extra cycle
    task automatic host_read(input logic [11:0] addr, input logic exp_err);
        apb_access(1'b0, addr, 32'h0);
        check_value("pslverr", 32'(rd_err), 32'(exp_err));
        check_value("pready wait", 32'(wait_cycles),
                    (addr >= `ACC_CPU_MEM_BASE && !exp_err) ? 32'd1 : 32'd0);
    endtask

    task automatic put_word(input logic [7:0] idx, input logic [15:0] word);
        model_mem[idx] = word;
        host_write(mem_addr(idx), {16'h0, word}, 1'b0);
    endtask

    function automatic logic [15:0] alu_model(input logic [3:0] code,
                                              input logic [15:0] a, input logic [15:0] b);
        logic [31:0] prod;
        logic [15:0] res;
        prod = {16'h0, a} * {16'h0, b};
        case (code)
            4'd0:  res = a + b;
            4'd1:  res = a - b;
            4'd2:  res = prod[15:0];
            4'd3:  res = (b == 16'h0) ? 16'hffff : a / b;
            4'd4:  res = {a[14:0], 1'b0};
            4'd5:  res = {1'b0, a[15:1]};
            4'd6:  res = {a[14:0], a[15]};
            4'd7:  res = {a[0], a[15:1]};
            4'd8:  res = a & b;
            4'd9:  res = a | b;
            4'd10: res = a ^ b;
            4'd11: res = ~(a | b);
            4'd12: res = ~(a & b);
            4'd13: res = ~(a ^ b);
            4'd14: res = {15'h0, a > b};
            default: res = {15'h0, a == b};
        endcase
        return res;
    endfunction

    // executes the image until halt and leaves pc on the halt word
    task automatic run_model(input logic [7:0] start_pc);
        logic [15:0] word;
        int          steps;
        logic        done;
        model_pc = start_pc;
        done     = 1'b0;
        steps    = 0;
        while (!done) begin
            word = model_mem[model_pc];
            case (word[15:12])
                CLS_LOAD:  model_acc = model_mem[word[7:0]];
                CLS_STORE: model_mem[word[7:0]] = model_acc;
                CLS_ALU:   model_acc = alu_model(word[11:8], model_acc, model_mem[word[7:0]]);
                default:   ;
            endcase
            if (word[15:12] == CLS_JUMP || (word[15:12] == CLS_JUMPZ && model_acc == 16'h0)) begin
                model_pc = word[7:0];
            end else if (word[15:12] <= CLS_JUMPZ) begin
                model_pc = model_pc + 8'd1;
            end else begin
                done = 1'b1;
            end
            steps++;
            if (steps > 10000) begin
                fail_now("reference model program did not halt");
            end
        end
    endtask

    // start pulse after which the core must be running
    task automatic start_program(input logic [7:0] start_pc);
        host_write(`ACC_CPU_REG_CTRL, {16'h0, start_pc, 8'h01}, 1'b0);
        host_read(`ACC_CPU_REG_STATUS, 1'b0);
        check_value("STATUS after start", rd_data, 32'd1);
    endtask

    task automatic finish_program(input logic [7:0] start_pc);
        int polls;
        polls = 0;
        host_read(`ACC_CPU_REG_STATUS, 1'b0);
        while (!rd_data[1]) begin
            polls++;
            if (polls > HALT_TIMEOUT) begin
                fail_now("program never halted");
            end else begin
                host_read(`ACC_CPU_REG_STATUS, 1'b0);
            end
        end
        run_model(start_pc);
        check_value("STATUS after halt", rd_data, 32'd2);
        host_read(`ACC_CPU_REG_ACC, 1'b0);
        check_value("ACC", rd_data, {16'h0, model_acc});
        host_read(`ACC_CPU_REG_PC, 1'b0);
        check_value("PC", rd_data, {24'h0, model_pc});
    endtask

    initial begin
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        seed      = 32'hde3e;
        model_acc = 16'h0;
        waited    = 0;
        while (arst_n !== 1'b1) begin
            waited++;
            if (waited > 20) begin
                fail_now("reset was never released");
            end else begin
                @(negedge clock);
            end
        end

        // state right after reset
        host_read(`ACC_CPU_REG_STATUS, 1'b0);
        check_value("STATUS", rd_data, 32'd0);
        host_read(`ACC_CPU_REG_ACC, 1'b0);
        check_value("ACC", rd_data, 32'd0);
        host_read(`ACC_CPU_REG_PC, 1'b0);
        check_value("PC", rd_data, 32'd0);

        // memory window round trip
        for (int i = 0; i < 8; i++) begin
            addrs[i] = 8'($random(seed));
            put_word(addrs[i], 16'($random(seed)));
        end
        for (int i = 0; i < 8; i++) begin
            host_read(mem_addr(addrs[i]), 1'b0);
            check_value("memory readback", rd_data, {16'h0, model_mem[addrs[i]]});
        end
        // unmapped offset errors and changes nothing
        host_read(12'h010, 1'b1);
        host_read(`ACC_CPU_REG_STATUS, 1'b0);
        check_value("STATUS", rd_data, 32'd0);
        host_read(mem_addr(addrs[0]), 1'b0);
        check_value("memory readback", rd_data, {16'h0, model_mem[addrs[0]]});

        // LOAD x then ALU op y then STORE and HALT for every op
        put_word(8'h10, instr(CLS_LOAD, 4'd0, 8'h80));
        put_word(8'h12, instr(CLS_STORE, 4'd0, 8'h82));
        put_word(8'h13, instr(CLS_HALT, 4'd0, 8'h00));
        // extra runs for div by zero and for equal operands
        for (int i = 0; i < 18; i++) begin
            op = (i == 16) ? 4'd3 : (i == 17) ? 4'd15 : 4'(i);
            x  = 16'($random(seed));
            y  = (i == 16) ? 16'h0 : (i == 17) ? x : 16'($random(seed));
            put_word(8'h80, x);
            put_word(8'h81, y);
            put_word(8'h11, instr(CLS_ALU, op, 8'h81));
            start_program(8'h10);
            finish_program(8'h10);
            host_read(mem_addr(8'h82), 1'b0);
            check_value("stored result", rd_data, {16'h0, model_mem[8'h82]});
        end

        // countdown loop that counts its passes at 0x92
        n = {13'h0, 3'($random(seed))} + 16'd3;
        put_word(8'h90, n);
        put_word(8'h91, 16'h1);
        put_word(8'h92, 16'h0);
        put_word(8'h20, instr(CLS_LOAD, 4'd0, 8'h90));
        put_word(8'h21, instr(CLS_JUMPZ, 4'd0, 8'h2a));
        put_word(8'h22, instr(CLS_ALU, 4'd1, 8'h91));
        put_word(8'h23, instr(CLS_STORE, 4'd0, 8'h90));
        put_word(8'h24, instr(CLS_LOAD, 4'd0, 8'h92));
        put_word(8'h25, instr(CLS_ALU, 4'd0, 8'h91));
        put_word(8'h26, instr(CLS_STORE, 4'd0, 8'h92));
        put_word(8'h27, instr(CLS_LOAD, 4'd0, 8'h90));
        put_word(8'h28, instr(CLS_JUMP, 4'd0, 8'h21));
        put_word(8'h29, instr(CLS_HALT, 4'd0, 8'h00));
        put_word(8'h2a, instr(CLS_HALT, 4'd0, 8'h00));
        start_program(8'h20);
        finish_program(8'h20);
        host_read(`ACC_CPU_REG_ACC, 1'b0);
        check_value("ACC after loop", rd_data, 32'd0);
        host_read(`ACC_CPU_REG_PC, 1'b0);
        check_value("PC after loop", rd_data, 32'h2a);
        host_read(mem_addr(8'h92), 1'b0);
        check_value("loop count", rd_data, {16'h0, n});

        // host accesses during a long run are refused
        put_word(8'h90, 16'd60);
        put_word(8'h92, 16'h0);
        put_word(8'ha0, 16'h5a5a);
        start_program(8'h20);
        host_write(mem_addr(8'ha0), 32'h1234, 1'b1);
        host_read(mem_addr(8'ha0), 1'b1);
        host_write(`ACC_CPU_REG_CTRL, {16'h0, 8'h10, 8'h01}, 1'b1);
        finish_program(8'h20);
        host_read(mem_addr(8'ha0), 1'b0);
        check_value("protected word", rd_data, 32'h5a5a);
        host_read(mem_addr(8'h92), 1'b0);
        check_value("loop count", rd_data, 32'd60);

        // restart from halted at another program
        x = 16'($random(seed));
        y = 16'($random(seed));
        put_word(8'h80, x);
        put_word(8'h81, y);
        put_word(8'h11, instr(CLS_ALU, 4'd0, 8'h81));
        start_program(8'h10);
        finish_program(8'h10);
        host_read(mem_addr(8'h82), 1'b0);
        check_value("stored result", rd_data, {16'h0, model_mem[8'h82]});

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
acc_cpu_pkg.sv
acc_cpu_alu.sv
acc_cpu_mem.sv
acc_cpu_core.sv
acc_cpu_apb_port.sv
acc_cpu_top.sv
tb_clock_gen.sv
tb_acc_cpu.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f list.f --top-module tb_acc_cpu -o tb_acc_cpu_sim &&
./obj_dir/tb_acc_cpu_sim ||
{ echo "simulation failed"; exit 1; }
